//--- common/axi_bus_pkg.sv
// AXI4 bus widths, burst and response codes
// Channel structs shared by the AW, W, B, AR and R paths
`default_nettype none

package axi_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  localparam int STRB_W = 4;
  localparam int LEN_W  = 8;
  localparam int SIZE_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;

  // WRAP is listed so that every legal code decodes
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // ----------------------------
  // Channel payloads
  // ----------------------------
  // Shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

endpackage

`default_nettype wire

//--- common/splitter_cfg_pkg.sv
// Splitter depth constants and the beat-count queue types
`default_nettype none

package splitter_cfg_pkg;

  // Bursts outstanding per direction
  localparam int MAX_TXNS = 4;
  localparam int QIDX_W   = 2;

  typedef logic [QIDX_W-1:0] qidx_t;
  // Queue occupancy, one bit wider than the index to count a full queue
  typedef logic [QIDX_W:0]   occ_t;

  // Remaining beats of a burst, len + 1 needs one extra bit
  typedef logic [axi_bus_pkg::LEN_W:0] cnt_t;

endpackage

`default_nettype wire

//--- ax_split/burst_len_queue.sv
// In-order circular queue of remaining beat counts
// Head entry counts down and pops when it reaches zero
`timescale 1ns/10ps
`default_nettype none

module burst_len_queue (
  input  wire  logic                   clk_i,
  input  wire  logic                   arst_n_i,
  input  wire  logic                   push_i,
  input  wire  splitter_cfg_pkg::cnt_t push_cnt_i,
  input  wire  logic                   dec_i,
  output logic                         full_o,
  output splitter_cfg_pkg::cnt_t       head_cnt_o,
  output logic                         head_valid_o
);

  splitter_cfg_pkg::cnt_t  mem_q [splitter_cfg_pkg::MAX_TXNS];
  splitter_cfg_pkg::qidx_t wr_ptr_q;
  splitter_cfg_pkg::qidx_t rd_ptr_q;
  splitter_cfg_pkg::occ_t  count_q;
  logic                    push_en;
  logic                    dec_en;
  logic                    pop;

  assign full_o       = (count_q == splitter_cfg_pkg::occ_t'(splitter_cfg_pkg::MAX_TXNS));
  assign head_valid_o = (count_q != '0);
  assign head_cnt_o   = mem_q[rd_ptr_q];

  assign push_en = push_i & ~full_o;
  assign dec_en  = dec_i & head_valid_o;
  // Last remaining beat leaves the queue in the same cycle
  assign pop     = dec_en & (head_cnt_o == splitter_cfg_pkg::cnt_t'(1));

  // ----------------------------
  // Pointers and occupancy
  // ----------------------------
  // MAX_TXNS is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_en, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Push never targets the head while the queue holds entries
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_cnt_i;
    end
    if (dec_en && !pop) begin
      mem_q[rd_ptr_q] <= head_cnt_o - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- ax_split/ax_split_chan.sv
// Address-channel splitter: idle/busy FSM issuing single-beat requests
// and recording each burst's beat count in a queue
`timescale 1ns/10ps
`default_nettype none

module ax_split_chan (
  input  wire  logic                     clk_i,
  input  wire  logic                     arst_n_i,
  input  wire  axi_bus_pkg::ax_chan_t    up_ax_i,
  input  wire  logic                     up_valid_i,
  output logic                           up_ready_o,
  output axi_bus_pkg::ax_chan_t          dn_ax_o,
  output logic                           dn_valid_o,
  input  wire  logic                     dn_ready_i,
  input  wire  logic                     rsp_dec_i,
  output splitter_cfg_pkg::cnt_t         head_cnt_o,
  output logic                           head_valid_o
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e                 state_q, state_d;
  axi_bus_pkg::ax_chan_t  ax_q, ax_d;
  logic                   q_full;
  logic                   q_push;
  splitter_cfg_pkg::cnt_t push_cnt;

  // Advance to the following beat; FIXED keeps its address
  function automatic axi_bus_pkg::ax_chan_t next_beat(input axi_bus_pkg::ax_chan_t ax);
    axi_bus_pkg::ax_chan_t nxt;
    nxt     = ax;
    nxt.len = ax.len - 1'b1;
    if (ax.burst == axi_bus_pkg::BURST_INCR) begin
      nxt.addr = ax.addr + (axi_bus_pkg::addr_t'(1) << ax.size);
    end
    return nxt;
  endfunction

  assign push_cnt = splitter_cfg_pkg::cnt_t'(up_ax_i.len) + splitter_cfg_pkg::cnt_t'(1);

  burst_len_queue burst_len_queue_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (q_push),
    .push_cnt_i   (push_cnt),
    .dec_i        (rsp_dec_i),
    .full_o       (q_full),
    .head_cnt_o   (head_cnt_o),
    .head_valid_o (head_valid_o)
  );

  always_comb begin
    state_d    = state_q;
    ax_d       = ax_q;
    q_push     = 1'b0;
    up_ready_o = 1'b0;
    dn_valid_o = 1'b0;
    dn_ax_o    = '0;
    case (state_q)
      ST_IDLE: begin
        if (up_valid_i && !q_full) begin
          dn_ax_o     = up_ax_i;
          dn_ax_o.len = '0;
          dn_valid_o  = 1'b1;
          if (up_ax_i.len == '0) begin
            // Single beat passes through once downstream takes it
            up_ready_o = dn_ready_i;
            q_push     = dn_ready_i;
          end else begin
            up_ready_o = 1'b1;
            q_push     = 1'b1;
            ax_d       = dn_ready_i ? next_beat(up_ax_i) : up_ax_i;
            state_d    = ST_BUSY;
          end
        end
      end
      ST_BUSY: begin
        dn_ax_o     = ax_q;
        dn_ax_o.len = '0;
        dn_valid_o  = 1'b1;
        if (dn_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = ST_IDLE;
          end else begin
            ax_d = next_beat(ax_q);
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

`default_nettype wire

//--- logic/b_merge.sv
// Write-response filter merging per-beat responses into one per burst
`timescale 1ns/10ps
`default_nettype none

module b_merge (
  input  wire  logic                   clk_i,
  input  wire  logic                   arst_n_i,
  input  wire  axi_bus_pkg::b_chan_t   dn_b_i,
  input  wire  logic                   dn_b_valid_i,
  output logic                         dn_b_ready_o,
  output axi_bus_pkg::b_chan_t         up_b_o,
  output logic                         up_b_valid_o,
  input  wire  logic                   up_b_ready_i,
  input  wire  splitter_cfg_pkg::cnt_t head_cnt_i,
  input  wire  logic                   head_valid_i,
  output logic                         dec_o
);

  typedef enum logic {ST_READY, ST_WAIT} state_e;

  state_e state_q, state_d;
  logic   err_q, err_d;
  logic   merged_err;

  // Sticky error of the head burst, including the beat on the bus
  assign merged_err = err_q | (dn_b_i.resp == axi_bus_pkg::RESP_SLVERR);

  always_comb begin
    state_d      = state_q;
    err_d        = err_q;
    dn_b_ready_o = 1'b0;
    up_b_valid_o = 1'b0;
    dec_o        = 1'b0;
    up_b_o       = dn_b_i;
    case (state_q)
      ST_READY: begin
        up_b_o.resp = merged_err ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;
        if (dn_b_valid_i && head_valid_i) begin
          dec_o = 1'b1;
          if (head_cnt_i == splitter_cfg_pkg::cnt_t'(1)) begin
            up_b_valid_o = 1'b1;
            if (up_b_ready_i) begin
              dn_b_ready_o = 1'b1;
              err_d        = 1'b0;
            end else begin
              // Keep the merged result while upstream stalls
              err_d   = merged_err;
              state_d = ST_WAIT;
            end
          end else begin
            // Intermediate beat is absorbed here
            dn_b_ready_o = 1'b1;
            err_d        = merged_err;
          end
        end
      end
      ST_WAIT: begin
        up_b_o.resp  = err_q ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;
        up_b_valid_o = 1'b1;
        if (up_b_ready_i) begin
          dn_b_ready_o = 1'b1;
          err_d        = 1'b0;
          state_d      = ST_READY;
        end
      end
      default: state_d = ST_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_READY;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/r_last_gen.sv
// Read-data stage rebuilding the last flag from the head beat count
`timescale 1ns/10ps
`default_nettype none

module r_last_gen (
  input  wire  logic                   clk_i,
  input  wire  logic                   arst_n_i,
  input  wire  axi_bus_pkg::r_chan_t   dn_r_i,
  input  wire  logic                   dn_r_valid_i,
  output logic                         dn_r_ready_o,
  output axi_bus_pkg::r_chan_t         up_r_o,
  output logic                         up_r_valid_o,
  input  wire  logic                   up_r_ready_i,
  input  wire  splitter_cfg_pkg::cnt_t head_cnt_i,
  input  wire  logic                   head_valid_i,
  output logic                         dec_o
);

  typedef enum logic {ST_FEED, ST_WAIT} state_e;

  state_e state_q, state_d;
  logic   last_q, last_d;

  always_comb begin
    state_d      = state_q;
    last_d       = last_q;
    dn_r_ready_o = 1'b0;
    up_r_valid_o = 1'b0;
    dec_o        = 1'b0;
    up_r_o       = dn_r_i;
    up_r_o.last  = 1'b0;
    case (state_q)
      ST_FEED: begin
        if (dn_r_valid_i && head_valid_i) begin
          last_d       = (head_cnt_i == splitter_cfg_pkg::cnt_t'(1));
          up_r_o.last  = last_d;
          up_r_valid_o = 1'b1;
          dec_o        = 1'b1;
          if (up_r_ready_i) begin
            dn_r_ready_o = 1'b1;
          end else begin
            state_d = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        // Count already taken, beat stays on the downstream bus
        up_r_o.last  = last_q;
        up_r_valid_o = 1'b1;
        if (up_r_ready_i) begin
          dn_r_ready_o = 1'b1;
          state_d      = ST_FEED;
        end
      end
      default: state_d = ST_FEED;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_FEED;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/burst_splitter.sv
// Burst splitter top: AW/AR splitters, write-response merge,
// read last rebuild and the write-data feedthrough
`timescale 1ns/10ps
`default_nettype none

module burst_splitter (
  input  wire  logic                 clk_i,
  input  wire  logic                 arst_n_i,
  // Upstream manager side
  input  wire  axi_bus_pkg::ax_chan_t s_aw_i,
  input  wire  logic                 s_aw_valid_i,
  output logic                       s_aw_ready_o,
  input  wire  axi_bus_pkg::w_chan_t s_w_i,
  input  wire  logic                 s_w_valid_i,
  output logic                       s_w_ready_o,
  output axi_bus_pkg::b_chan_t       s_b_o,
  output logic                       s_b_valid_o,
  input  wire  logic                 s_b_ready_i,
  input  wire  axi_bus_pkg::ax_chan_t s_ar_i,
  input  wire  logic                 s_ar_valid_i,
  output logic                       s_ar_ready_o,
  output axi_bus_pkg::r_chan_t       s_r_o,
  output logic                       s_r_valid_o,
  input  wire  logic                 s_r_ready_i,
  // Downstream subordinate side
  output axi_bus_pkg::ax_chan_t      m_aw_o,
  output logic                       m_aw_valid_o,
  input  wire  logic                 m_aw_ready_i,
  output axi_bus_pkg::w_chan_t       m_w_o,
  output logic                       m_w_valid_o,
  input  wire  logic                 m_w_ready_i,
  input  wire  axi_bus_pkg::b_chan_t m_b_i,
  input  wire  logic                 m_b_valid_i,
  output logic                       m_b_ready_o,
  output axi_bus_pkg::ax_chan_t      m_ar_o,
  output logic                       m_ar_valid_o,
  input  wire  logic                 m_ar_ready_i,
  input  wire  axi_bus_pkg::r_chan_t m_r_i,
  input  wire  logic                 m_r_valid_i,
  output logic                       m_r_ready_o
);

  splitter_cfg_pkg::cnt_t aw_head_cnt;
  logic                   aw_head_valid;
  logic                   aw_dec;
  splitter_cfg_pkg::cnt_t ar_head_cnt;
  logic                   ar_head_valid;
  logic                   ar_dec;

  // ----------------------------
  // Write path
  // ----------------------------
  ax_split_chan aw_split_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .up_ax_i      (s_aw_i),
    .up_valid_i   (s_aw_valid_i),
    .up_ready_o   (s_aw_ready_o),
    .dn_ax_o      (m_aw_o),
    .dn_valid_o   (m_aw_valid_o),
    .dn_ready_i   (m_aw_ready_i),
    .rsp_dec_i    (aw_dec),
    .head_cnt_o   (aw_head_cnt),
    .head_valid_o (aw_head_valid)
  );

  // Every downstream write is a single beat
  always_comb begin
    m_w_o      = s_w_i;
    m_w_o.last = 1'b1;
  end
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  b_merge b_merge_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dn_b_i       (m_b_i),
    .dn_b_valid_i (m_b_valid_i),
    .dn_b_ready_o (m_b_ready_o),
    .up_b_o       (s_b_o),
    .up_b_valid_o (s_b_valid_o),
    .up_b_ready_i (s_b_ready_i),
    .head_cnt_i   (aw_head_cnt),
    .head_valid_i (aw_head_valid),
    .dec_o        (aw_dec)
  );

  // ----------------------------
  // Read path
  // ----------------------------
  ax_split_chan ar_split_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .up_ax_i      (s_ar_i),
    .up_valid_i   (s_ar_valid_i),
    .up_ready_o   (s_ar_ready_o),
    .dn_ax_o      (m_ar_o),
    .dn_valid_o   (m_ar_valid_o),
    .dn_ready_i   (m_ar_ready_i),
    .rsp_dec_i    (ar_dec),
    .head_cnt_o   (ar_head_cnt),
    .head_valid_o (ar_head_valid)
  );

  r_last_gen r_last_gen_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dn_r_i       (m_r_i),
    .dn_r_valid_i (m_r_valid_i),
    .dn_r_ready_o (m_r_ready_o),
    .up_r_o       (s_r_o),
    .up_r_valid_o (s_r_valid_o),
    .up_r_ready_i (s_r_ready_i),
    .head_cnt_i   (ar_head_cnt),
    .head_valid_i (ar_head_valid),
    .dec_o        (ar_dec)
  );

endmodule

`default_nettype wire

//--- verification/tb_axi_mem_model.sv
// Downstream AXI subordinate model for the testbench
// Word memory, one error address and in-order B and R queues
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem_model (
  input  wire  logic                  clk_i,
  input  wire  logic                  arst_n_i,
  // Ready drops for AW, W and AR
  input  wire  logic [2:0]            stall_i,
  input  wire  axi_bus_pkg::ax_chan_t aw_i,
  input  wire  logic                  aw_valid_i,
  output logic                        aw_ready_o,
  input  wire  axi_bus_pkg::w_chan_t  w_i,
  input  wire  logic                  w_valid_i,
  output logic                        w_ready_o,
  output axi_bus_pkg::b_chan_t        b_o,
  output logic                        b_valid_o,
  input  wire  logic                  b_ready_i,
  input  wire  axi_bus_pkg::ax_chan_t ar_i,
  input  wire  logic                  ar_valid_i,
  output logic                        ar_ready_o,
  output axi_bus_pkg::r_chan_t        r_o,
  output logic                        r_valid_o,
  input  wire  logic                  r_ready_i
);

  // Any write beat to this address answers SLVERR
  localparam logic [31:0] ERR_ADDR = 32'h0000_0200;

  axi_bus_pkg::data_t    mem [1024];
  axi_bus_pkg::ax_chan_t aw_q [$];
  axi_bus_pkg::data_t    w_q [$];
  axi_bus_pkg::b_chan_t  b_q [$];
  axi_bus_pkg::r_chan_t  r_q [$];

  assign aw_ready_o = ~stall_i[0];
  assign w_ready_o  = ~stall_i[1];
  assign ar_ready_o = ~stall_i[2];

  initial begin : serve
    logic                  aw_hs;
    logic                  w_hs;
    logic                  b_hs;
    logic                  ar_hs;
    logic                  r_hs;
    axi_bus_pkg::ax_chan_t aw;
    axi_bus_pkg::ax_chan_t ar;
    axi_bus_pkg::data_t    wdata;
    axi_bus_pkg::b_chan_t  b;
    axi_bus_pkg::r_chan_t  r;
    b_o       = '0;
    b_valid_o = 1'b0;
    r_o       = '0;
    r_valid_o = 1'b0;
    forever begin
      @(posedge clk_i);
      // Handshakes and payloads as seen on the edge
      aw_hs = aw_valid_i & aw_ready_o;
      w_hs  = w_valid_i & w_ready_o;
      b_hs  = b_valid_o & b_ready_i;
      ar_hs = ar_valid_i & ar_ready_o;
      r_hs  = r_valid_o & r_ready_i;
      aw    = aw_i;
      ar    = ar_i;
      wdata = w_i.data;
      #1;
      if (!arst_n_i) begin
        aw_q.delete();
        w_q.delete();
        b_q.delete();
        r_q.delete();
      end else begin
        if (b_hs) begin
          void'(b_q.pop_front());
        end
        if (r_hs) begin
          void'(r_q.pop_front());
        end
        if (aw_hs) begin
          aw_q.push_back(aw);
        end
        if (w_hs) begin
          w_q.push_back(wdata);
        end
        // Pair each address beat with its data beat
        while (aw_q.size() != 0 && w_q.size() != 0) begin
          aw    = aw_q.pop_front();
          wdata = w_q.pop_front();
          mem[aw.addr[11:2]] = wdata;
          b.id   = aw.id;
          b.resp = (aw.addr == ERR_ADDR) ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;
          b_q.push_back(b);
        end
        if (ar_hs) begin
          r.id   = ar.id;
          r.data = mem[ar.addr[11:2]];
          r.resp = axi_bus_pkg::RESP_OKAY;
          r.last = 1'b1;
          r_q.push_back(r);
        end
      end
      b_valid_o = (b_q.size() != 0);
      b_o       = b_valid_o ? b_q[0] : '0;
      r_valid_o = (r_q.size() != 0);
      r_o       = r_valid_o ? r_q[0] : '0;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_burst_splitter.sv
// Burst splitter testbench with vector sequencer, clock, reset, LFSR stalls,
// bus monitors and checks, watchdog and reporting
`timescale 1ns/10ps
`default_nettype none

module tb_burst_splitter;

  localparam int CLK_PERIOD  = 100;
  localparam int MAX_TESTS   = 32;
  // Cycles allowed per beat and per test with every ready stalling
  localparam int BEAT_MARGIN = 16;
  localparam int TEST_MARGIN = 40;

  typedef struct packed {
    logic               is_rd;
    axi_bus_pkg::id_t   id;
    axi_bus_pkg::addr_t addr;
    axi_bus_pkg::len_t  len;
    axi_bus_pkg::size_t size;
    logic [1:0]         burst;
    axi_bus_pkg::data_t seed;
    logic [1:0]         resp;
  } vec_t;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  axi_bus_pkg::ax_chan_t s_aw_i;
  logic                  s_aw_valid_i;
  logic                  s_aw_ready_o;
  axi_bus_pkg::w_chan_t  s_w_i;
  logic                  s_w_valid_i;
  logic                  s_w_ready_o;
  axi_bus_pkg::b_chan_t  s_b_o;
  logic                  s_b_valid_o;
  logic                  s_b_ready_i;
  axi_bus_pkg::ax_chan_t s_ar_i;
  logic                  s_ar_valid_i;
  logic                  s_ar_ready_o;
  axi_bus_pkg::r_chan_t  s_r_o;
  logic                  s_r_valid_o;
  logic                  s_r_ready_i;
  axi_bus_pkg::ax_chan_t m_aw_o;
  logic                  m_aw_valid_o;
  logic                  m_aw_ready_i;
  axi_bus_pkg::w_chan_t  m_w_o;
  logic                  m_w_valid_o;
  logic                  m_w_ready_i;
  axi_bus_pkg::b_chan_t  m_b_i;
  logic                  m_b_valid_i;
  logic                  m_b_ready_o;
  axi_bus_pkg::ax_chan_t m_ar_o;
  logic                  m_ar_valid_o;
  logic                  m_ar_ready_i;
  axi_bus_pkg::r_chan_t  m_r_i;
  logic                  m_r_valid_i;
  logic                  m_r_ready_o;

  string       name_a [MAX_TESTS];
  vec_t        vec_a [MAX_TESTS];
  int          n_tests;
  int          total_beats;
  int          exp_b_total;
  int          exp_r_total;
  logic        vectors_loaded = 1'b0;
  vec_t        cur;
  string       cur_name;
  int          aw_total = 0;
  int          w_total = 0;
  int          ar_total = 0;
  int          b_total = 0;
  int          r_total = 0;
  int          aw_base;
  int          w_base;
  int          ar_base;
  int          b_base;
  int          r_base;
  int          err_count = 0;
  int          fail_tests = 0;
  logic [31:0] lfsr_q = 32'hdefe_b772;
  logic        stall_en;
  logic [2:0]  model_stall;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  burst_splitter burst_splitter_inst (
    .clk_i, .arst_n_i,
    .s_aw_i, .s_aw_valid_i, .s_aw_ready_o, .s_w_i, .s_w_valid_i, .s_w_ready_o,
    .s_b_o, .s_b_valid_o, .s_b_ready_i, .s_ar_i, .s_ar_valid_i, .s_ar_ready_o,
    .s_r_o, .s_r_valid_o, .s_r_ready_i,
    .m_aw_o, .m_aw_valid_o, .m_aw_ready_i, .m_w_o, .m_w_valid_o, .m_w_ready_i,
    .m_b_i, .m_b_valid_i, .m_b_ready_o, .m_ar_o, .m_ar_valid_o, .m_ar_ready_i,
    .m_r_i, .m_r_valid_i, .m_r_ready_o
  );

  tb_axi_mem_model tb_axi_mem_model_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .stall_i    (model_stall),
    .aw_i       (m_aw_o),
    .aw_valid_i (m_aw_valid_o),
    .aw_ready_o (m_aw_ready_i),
    .w_i        (m_w_o),
    .w_valid_i  (m_w_valid_o),
    .w_ready_o  (m_w_ready_i),
    .b_o        (m_b_i),
    .b_valid_o  (m_b_valid_i),
    .b_ready_i  (m_b_ready_o),
    .ar_i       (m_ar_o),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_o (m_ar_ready_i),
    .r_o        (m_r_i),
    .r_valid_o  (m_r_valid_i),
    .r_ready_i  (m_r_ready_o)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %0s %0s: expected %0h actual %0h", cur_name, what, exp, act);
    err_count++;
  endtask

  task automatic report_error(input string msg);
    $display("error in %0s: %0s", cur_name, msg);
    err_count++;
  endtask

  // ------------------------------
  // Vector file
  // ------------------------------
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       nm;
    string       op;
    logic [31:0] f_id;
    logic [31:0] f_addr;
    logic [31:0] f_len;
    logic [31:0] f_size;
    logic [31:0] f_burst;
    logic [31:0] f_seed;
    logic [31:0] f_resp;
    n_tests     = 0;
    total_beats = 0;
    exp_b_total = 0;
    exp_r_total = 0;
    cur_name    = "load";
    fd = $fopen("verification/burst_input.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verification/burst_input.txt");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", nm, op, f_id, f_addr,
                      f_len, f_size, f_burst, f_seed, f_resp);
          if (n == 9) begin
            name_a[n_tests] = nm;
            vec_a[n_tests]  = '{is_rd: (op == "r"), id: f_id[3:0], addr: f_addr,
                                len: f_len[7:0], size: f_size[2:0], burst: f_burst[1:0],
                                seed: f_seed, resp: f_resp[1:0]};
            total_beats += int'(f_len[7:0]) + 1;
            if (op == "r") begin
              exp_r_total += int'(f_len[7:0]) + 1;
            end else begin
              exp_b_total += 1;
            end
            n_tests++;
          end else begin
            report_error($sformatf("unreadable vector line: %0s", line));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // Upstream drivers
  // ------------------------------
  task automatic send_addr();
    axi_bus_pkg::ax_chan_t ax;
    ax.id    = cur.id;
    ax.addr  = cur.addr;
    ax.len   = cur.len;
    ax.size  = cur.size;
    ax.burst = axi_bus_pkg::burst_e'(cur.burst);
    @(posedge clk_i);
    #1;
    if (cur.is_rd) begin
      s_ar_i       = ax;
      s_ar_valid_i = 1'b1;
    end else begin
      s_aw_i       = ax;
      s_aw_valid_i = 1'b1;
    end
    @(posedge clk_i);
    while (!(cur.is_rd ? s_ar_ready_o : s_aw_ready_o)) begin
      @(posedge clk_i);
    end
    #1;
    s_ar_valid_i = 1'b0;
    s_aw_valid_i = 1'b0;
  endtask

  task automatic send_write_data();
    for (int k = 0; k <= int'(cur.len); k++) begin
      s_w_i.data  = cur.seed + 32'(k);
      s_w_i.strb  = '1;
      s_w_i.last  = (k == int'(cur.len));
      s_w_valid_i = 1'b1;
      @(posedge clk_i);
      while (!s_w_ready_o) begin
        @(posedge clk_i);
      end
      #1;
    end
    s_w_valid_i = 1'b0;
  endtask

  task automatic run_test(input int idx, input string tag);
    int errs_before;
    int beats;
    cur         = vec_a[idx];
    cur_name    = name_a[idx];
    beats       = int'(cur.len) + 1;
    errs_before = err_count;
    aw_base     = aw_total;
    w_base      = w_total;
    ar_base     = ar_total;
    b_base      = b_total;
    r_base      = r_total;
    send_addr();
    if (cur.is_rd) begin
      while (r_total - r_base < beats) begin
        @(posedge clk_i);
      end
      #1;
      if (ar_total - ar_base != beats) begin
        report_mismatch("ar_beats", beats, ar_total - ar_base);
      end
    end else begin
      send_write_data();
      while (b_total == b_base) begin
        @(posedge clk_i);
      end
      #1;
      if (aw_total - aw_base != beats) begin
        report_mismatch("aw_beats", beats, aw_total - aw_base);
      end
      if (w_total - w_base != beats) begin
        report_mismatch("w_beats", beats, w_total - w_base);
      end
    end
    if (err_count != errs_before) begin
      fail_tests++;
    end
    $display("%0s %0s: %0s", tag, cur_name, (err_count == errs_before) ? "ok" : "failed");
  endtask

  // ------------------------------
  // Monitors
  // ------------------------------
  task automatic check_ax(input string ch, input axi_bus_pkg::ax_chan_t ax, input int k,
                          input logic rd_chan);
    logic [31:0] exp_addr;
    exp_addr = cur.addr;
    if (cur.burst == axi_bus_pkg::BURST_INCR) begin
      exp_addr = cur.addr + (32'(k) << cur.size);
    end
    if (rd_chan != cur.is_rd || k > int'(cur.len)) begin
      report_error($sformatf("unexpected downstream %0s beat", ch));
    end
    if (ax.len !== '0) begin
      report_mismatch({ch, "_len"}, 0, ax.len);
    end
    if (ax.addr !== exp_addr) begin
      report_mismatch({ch, "_addr"}, exp_addr, ax.addr);
    end
    if (ax.id !== cur.id) begin
      report_mismatch({ch, "_id"}, cur.id, ax.id);
    end
  endtask

  always @(posedge clk_i) begin : monitor
    int k;
    if (arst_n_i) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        check_ax("aw", m_aw_o, aw_total - aw_base, 1'b0);
        aw_total <= aw_total + 1;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        check_ax("ar", m_ar_o, ar_total - ar_base, 1'b1);
        ar_total <= ar_total + 1;
      end
      if (m_w_valid_o && m_w_ready_i) begin
        k = w_total - w_base;
        if (m_w_o.last !== 1'b1) begin
          report_mismatch("w_last", 1, m_w_o.last);
        end
        if (m_w_o.data !== cur.seed + 32'(k)) begin
          report_mismatch("w_data", cur.seed + 32'(k), m_w_o.data);
        end
        w_total <= w_total + 1;
      end
      if (s_b_valid_o && s_b_ready_i) begin
        if (cur.is_rd || b_total != b_base) begin
          report_error("unexpected or duplicate write response");
        end
        if (s_b_o.id !== cur.id) begin
          report_mismatch("b_id", cur.id, s_b_o.id);
        end
        if (s_b_o.resp !== cur.resp) begin
          report_mismatch("b_resp", cur.resp, s_b_o.resp);
        end
        b_total <= b_total + 1;
      end
      if (s_r_valid_o && s_r_ready_i) begin
        k = r_total - r_base;
        if (!cur.is_rd || k > int'(cur.len)) begin
          report_error("unexpected read beat");
        end
        if (s_r_o.data !== cur.seed + 32'(k)) begin
          report_mismatch("r_data", cur.seed + 32'(k), s_r_o.data);
        end
        if (s_r_o.last !== (k == int'(cur.len))) begin
          report_mismatch("r_last", (k == int'(cur.len)), s_r_o.last);
        end
        if (s_r_o.id !== cur.id) begin
          report_mismatch("r_id", cur.id, s_r_o.id);
        end
        if (s_r_o.resp !== cur.resp) begin
          report_mismatch("r_resp", cur.resp, s_r_o.resp);
        end
        r_total <= r_total + 1;
      end
    end
  end

  // Ready drops from five LFSR bits per cycle
  always @(posedge clk_i) begin : stall_gen
    logic [4:0] drop;
    #1;
    drop = '0;
    if (stall_en) begin
      for (int i = 0; i < 5; i++) begin
        lfsr_q  = lfsr_next(lfsr_q);
        drop[i] = lfsr_q[0];
      end
    end
    model_stall = drop[2:0];
    s_b_ready_i = ~drop[3];
    s_r_ready_i = ~drop[4];
  end

  initial begin : watchdog
    longint limit;
    wait (vectors_loaded);
    limit = 2 * (longint'(total_beats) * BEAT_MARGIN + longint'(n_tests) * TEST_MARGIN) + 100;
    #(limit * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : sequencer
    arst_n_i     = 1'b0;
    s_aw_i       = '0;
    s_aw_valid_i = 1'b0;
    s_w_i        = '0;
    s_w_valid_i  = 1'b0;
    s_b_ready_i  = 1'b1;
    s_ar_i       = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i  = 1'b1;
    stall_en     = 1'b0;
    model_stall  = '0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // First round runs without stalls and the second with LFSR stalls on every ready
    for (int round = 0; round < 2; round++) begin
      @(negedge clk_i);
      stall_en = (round == 1);
      for (int t = 0; t < n_tests; t++) begin
        run_test(t, (round == 1) ? "stall" : "plain");
      end
    end
    repeat (4) @(posedge clk_i);
    cur_name = "summary";
    if (b_total != 2 * exp_b_total) begin
      report_mismatch("b_responses", 2 * exp_b_total, b_total);
    end
    if (r_total != 2 * exp_r_total) begin
      report_mismatch("r_beats", 2 * exp_r_total, r_total);
    end
    $display("tests %0d, failed %0d, check errors %0d", 2 * n_tests, fail_tests, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/burst_input.txt
# name op(w/r) id addr len size burst(0 FIXED, 1 INCR) seed resp(0 OKAY, 2 SLVERR)
# numbers in hex, write beat k carries seed + k, a read expects the same words back
wr_single     w 1 00000010 00 2 1 11110000 0
rd_single     r 1 00000010 00 2 1 11110000 0
wr_incr4      w 2 00000100 03 2 1 a5a50000 0
rd_incr4      r 2 00000100 03 2 1 a5a50000 0
wr_incr16     w 3 00000300 0f 2 1 c0de0000 0
rd_incr16     r 4 00000300 0f 2 1 c0de0000 0
wr_fixed4     w 5 00000040 03 2 0 f1f10000 0
rd_fixed_chk  r 5 00000040 00 2 1 f1f10003 0
wr_fixed_one  w 0 00000080 00 2 0 abcd0000 0
rd_fixed_one  r 0 00000080 00 2 0 abcd0000 0
wr_err_mid    w 6 000001f8 03 2 1 e0e00000 2
wr_err_one    w 7 00000200 00 2 1 e1e10000 2
wr_fixed_err  w 8 00000200 02 2 0 e2e20000 2
wr_err_near   w 9 000001e0 03 2 1 e3e30000 0
wr_half       w a 00000400 03 1 1 b0b00000 0
wr_byte       w b 00000500 02 0 1 b1b10000 0
wr_incr8      w c 00000600 07 2 1 d0d00000 0
rd_incr8      r c 00000600 07 2 1 d0d00000 0
rd_incr4_mid  r d 00000608 03 2 1 d0d00002 0
wr_incr256    w e 00000c00 ff 2 1 77770000 0
rd_incr256    r f 00000c00 ff 2 1 77770000 0
wr_incr2      w 1 00000700 01 2 1 12340000 0
rd_incr2      r 2 00000700 01 2 1 12340000 0

//--- burst_splitter.f
common/axi_bus_pkg.sv
common/splitter_cfg_pkg.sv
ax_split/burst_len_queue.sv
ax_split/ax_split_chan.sv
logic/b_merge.sv
logic/r_last_gen.sv
logic/burst_splitter.sv
verification/tb_axi_mem_model.sv
verification/tb_burst_splitter.sv
